// ==== tb.f ====
verilog/net_proto_pkg.sv
verilog/frame_gen_pkg.sv
verilog/tx_credit_counter.sv
verilog/ipv4_checksum.sv
verilog/header_store.sv
verilog/frame_sequencer.sv
verilog/frame_generator.sv
testbench/frame_generator_chk.sv
testbench/frame_generator_tb.sv

// ==== testbench/frame_generator_tb.sv ====
`timescale 1ns/1ps

module frame_generator_tb import net_proto_pkg::*, frame_gen_pkg::*; ();

    typedef struct packed {
        logic [47:0] mac_destination;
        logic [47:0] mac_source;
        logic [31:0] ipv4_source;
        logic [31:0] ipv4_destination;
        logic [15:0] identification;
        logic [15:0] flags;
        logic [15:0] udp_source;
        logic [15:0] udp_destination;
        logic [15:0] udp_checksum;
        logic [15:0] payload_size;
        logic [15:0] fragment_size;
        logic [7:0]  pattern;
        logic        random_credits;
        logic [15:0] frame_bytes;
    } frame_row_t;

    localparam int ROW_COUNT = 5;
    localparam int WAIT_LIMIT = 3000;

    logic clock;
    logic reset_n;
    logic start;
    logic [47:0] mac_destination;
    logic [47:0] mac_source;
    logic [31:0] ipv4_source;
    logic [31:0] ipv4_destination;
    logic [15:0] ipv4_identification;
    ipv4_flags_t ipv4_flags;
    logic [15:0] udp_source;
    logic [15:0] udp_destination;
    logic [15:0] udp_checksum;
    logic [15:0] udp_payload_size;
    logic [15:0] udp_fragment_size;
    logic [7:0]  payload_read_data;
    logic        credit_return;
    logic        ready;
    logic [7:0]  frame_data;
    logic        frame_valid;
    logic        frame_last;
    logic [PAYLOAD_ADDR_WIDTH-1:0] payload_read_address;

    frame_row_t rows [ROW_COUNT];
    logic [7:0] received [$];
    logic [7:0] expected [$];
    int         credit_due [$];
    int         cycle_count = 0;
    int         last_index = 0;
    logic       random_credits = 1'b0;
    logic [7:0] pattern = 8'h00;
    integer     seed = 32'hcff2_eb01;

    frame_generator i_dut (.*);

    bind frame_generator frame_generator_chk i_chk (
        .clock         (clock),
        .reset_n       (reset_n),
        .ready         (ready),
        .frame_valid   (frame_valid),
        .frame_last    (frame_last),
        .credit_return (credit_return)
    );

    // Payload buffer contents depend on every address bit
    function automatic logic [7:0] payload_byte(input logic [7:0] seed_byte,
                                                input logic [15:0] address);
        payload_byte = seed_byte ^ address[7:0] ^ address[15:8] ^ {address[4:0], 3'b000};
    endfunction

    assign payload_read_data = payload_byte(pattern, payload_read_address);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic stop_on_failure();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] wanted);
        if (actual !== wanted) begin
            $display("[FAIL] time %0t %s = %0h, expected %0h", $time, name, actual, wanted);
            stop_on_failure();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out while waiting for %s", what);
        stop_on_failure();
    endtask

    always @(posedge clock) begin
        if (i_dut.i_chk.failure_count != 0) begin
            stop_on_failure();
        end
    end

    ////////////////////////////////////////////////////////////
    // One clock of the receiver side
    ////////////////////////////////////////////////////////////

    task automatic step_cycle();
        int due;
        @(posedge clock);
        #2;
        cycle_count++;
        if (frame_valid) begin
            received.push_back(frame_data);
            due = cycle_count;
            if (random_credits) begin
                due = due + int'($unsigned($random(seed)) % 6);
            end
            credit_due.push_back(due);
            if (frame_last) begin
                last_index = received.size();
            end
        end
        credit_return = 1'b0;
        if (credit_due.size() != 0 && credit_due[0] <= cycle_count) begin
            void'(credit_due.pop_front());
            credit_return = 1'b1;
        end
    endtask

    task automatic push_bytes(input logic [47:0] value, input int count);
        for (int i = count - 1; i >= 0; i--) begin
            expected.push_back(value[8 * i +: 8]);
        end
    endtask

    // Reference frame built from the protocol rules
    task automatic build_expected(input frame_row_t row);
        logic        first;
        logic [15:0] total;
        logic [31:0] sum;
        expected.delete();
        first = (row.flags[12:0] == 13'd0);
        total = 16'd20 + row.fragment_size + (first ? 16'd8 : 16'd0);
        sum = 32'h4500 + total + row.identification + row.flags + 32'h8011
            + row.ipv4_source[31:16] + row.ipv4_source[15:0]
            + row.ipv4_destination[31:16] + row.ipv4_destination[15:0];
        while (sum[31:16] != 16'd0) begin
            sum = sum[15:0] + sum[31:16];
        end
        push_bytes(row.mac_destination, 6);
        push_bytes(row.mac_source, 6);
        push_bytes(48'h0800, 2);
        push_bytes({16'h0, 16'h4500, total}, 4);
        push_bytes({16'h0, row.identification, row.flags}, 4);
        push_bytes({32'h0, 16'h8011}, 2);
        push_bytes({32'h0, ~sum[15:0]}, 2);
        push_bytes({16'h0, row.ipv4_source}, 4);
        push_bytes({16'h0, row.ipv4_destination}, 4);
        if (first) begin
            push_bytes({32'h0, row.udp_source}, 2);
            push_bytes({32'h0, row.udp_destination}, 2);
            push_bytes({32'h0, row.payload_size + 16'd8}, 2);
            push_bytes({32'h0, row.udp_checksum}, 2);
        end
        for (int i = 0; i < row.fragment_size; i++) begin
            expected.push_back(payload_byte(row.pattern, 16'(i)));
        end
        while (expected.size() < 60) begin
            expected.push_back(8'h00);
        end
    endtask

    task automatic run_frame(input frame_row_t row);
        int timeout;
        timeout = 0;
        while (!ready) begin
            step_cycle();
            timeout++;
            if (timeout > WAIT_LIMIT) report_timeout("ready before a frame");
        end
        build_expected(row);
        received.delete();
        last_index = 0;
        random_credits = row.random_credits;
        pattern = row.pattern;
        mac_destination = row.mac_destination;
        mac_source = row.mac_source;
        ipv4_source = row.ipv4_source;
        ipv4_destination = row.ipv4_destination;
        ipv4_identification = row.identification;
        ipv4_flags = row.flags;
        udp_source = row.udp_source;
        udp_destination = row.udp_destination;
        udp_checksum = row.udp_checksum;
        udp_payload_size = row.payload_size;
        udp_fragment_size = row.fragment_size;
        start = 1'b1;
        step_cycle();
        start = 1'b0;
        timeout = 0;
        while (last_index == 0) begin
            check_value("ready", ready, 0);
            // Stray start while busy, with changed inputs
            start = (timeout == 3);
            if (timeout == 3) mac_destination = ~row.mac_destination;
            step_cycle();
            start = 1'b0;
            timeout++;
            if (timeout > WAIT_LIMIT) report_timeout("frame_last");
        end
        check_value("ready", ready, 0);
        // One address step per payload byte sent
        check_value("payload_read_address", payload_read_address, row.fragment_size);
        step_cycle();
        check_value("ready", ready, 1);
        check_value("frame length", received.size(), row.frame_bytes);
        check_value("model length", expected.size(), row.frame_bytes);
        check_value("frame_last position", last_index, row.frame_bytes);
        foreach (expected[i]) begin
            check_value($sformatf("frame_data[%0d]", i), received[i], expected[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int timeout;
        reset_n = 1'b0;
        start = 1'b0;
        credit_return = 1'b0;
        mac_destination = '0;
        mac_source = '0;
        ipv4_source = '0;
        ipv4_destination = '0;
        ipv4_identification = '0;
        ipv4_flags = '0;
        udp_source = '0;
        udp_destination = '0;
        udp_checksum = '0;
        udp_payload_size = '0;
        udp_fragment_size = '0;

        rows[0] = '{48'h0200_0000_00a1, 48'h0200_0000_00b2, 32'hc0a8_0001, 32'hc0a8_0002,
                    16'h1234, 16'h4000, 16'd5000, 16'd6000, 16'hbeef,
                    16'd40, 16'd40, 8'h3c, 1'b0, 16'd82};
        rows[1] = '{48'hffff_ffff_ffff, 48'h0a1b_2c3d_4e5f, 32'h0a00_0005, 32'h0a00_00ff,
                    16'h0001, 16'h0000, 16'd68, 16'd67, 16'h0000,
                    16'd6, 16'd6, 8'h91, 1'b0, 16'd60};
        rows[2] = '{48'h0011_2233_4455, 48'h6677_8899_aabb, 32'hac10_fe01, 32'hac10_0a0b,
                    16'hfffe, 16'h0005, 16'd1024, 16'd2048, 16'h1111,
                    16'd200, 16'd30, 8'h5a, 1'b0, 16'd64};
        rows[3] = rows[0];
        rows[3].random_credits = 1'b1;
        rows[4] = '{48'h0200_0000_00c3, 48'h0200_0000_00d4, 32'hffff_fff0, 32'h8080_8080,
                    16'h7f00, 16'h2003, 16'd80, 16'd8080, 16'h2222,
                    16'd100, 16'd10, 8'he7, 1'b1, 16'd60};

        for (int i = 0; i < 8; i++) begin
            step_cycle();
            check_value("frame_valid", frame_valid, 0);
            check_value("frame_last", frame_last, 0);
            check_value("ready", ready, 0);
        end
        reset_n = 1'b1;
        check_value("ready", ready, 0);
        step_cycle();
        check_value("ready", ready, 1);

        for (int r = 0; r < ROW_COUNT; r++) begin
            run_frame(rows[r]);
        end

        timeout = 0;
        while (credit_due.size() != 0) begin
            step_cycle();
            timeout++;
            if (timeout > WAIT_LIMIT) report_timeout("the last credit returns");
        end
        step_cycle();

        if (i_dut.i_chk.failure_count == 0) begin
            $display("Test OK");
            $finish;
        end
        else begin
            stop_on_failure();
        end
    end

endmodule

// ==== testbench/frame_generator_chk.sv ====
`timescale 1ns/1ps

module frame_generator_chk import frame_gen_pkg::*; (
    input logic clock,
    input logic reset_n,
    input logic ready,
    input logic frame_valid,
    input logic frame_last,
    input logic credit_return
);

    // Bytes seen on the port whose credit has not come back yet
    int outstanding;
    int failure_count = 0;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            outstanding <= 0;
        end
        else begin
            outstanding <= outstanding + int'(frame_valid) - int'(credit_return);
        end
    end

    credits_bounded: assert property (@(posedge clock) disable iff (!reset_n)
        outstanding + int'(frame_valid) <= TX_CREDITS)
        else begin
            failure_count++;
            $error("more bytes outstanding than credits granted");
        end

    last_with_valid: assert property (@(posedge clock) disable iff (!reset_n)
        frame_last |-> frame_valid)
        else begin
            failure_count++;
            $error("frame_last high without frame_valid");
        end

    ready_not_sending: assert property (@(posedge clock) disable iff (!reset_n)
        !(ready && frame_valid))
        else begin
            failure_count++;
            $error("ready and frame_valid high together");
        end

endmodule

// ==== verilog/frame_generator.sv ====
`timescale 1ns/1ps

module frame_generator import net_proto_pkg::*, frame_gen_pkg::*; (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic                          start,
    input  logic [47:0]                   mac_destination,
    input  logic [47:0]                   mac_source,
    input  logic [31:0]                   ipv4_source,
    input  logic [31:0]                   ipv4_destination,
    input  logic [15:0]                   ipv4_identification,
    input  ipv4_flags_t                   ipv4_flags,
    input  logic [15:0]                   udp_source,
    input  logic [15:0]                   udp_destination,
    input  logic [15:0]                   udp_checksum,
    input  logic [15:0]                   udp_payload_size,
    input  logic [15:0]                   udp_fragment_size,
    input  logic [7:0]                    payload_read_data,
    input  logic                          credit_return,
    output logic                          ready,
    output logic [7:0]                    frame_data,
    output logic                          frame_valid,
    output logic                          frame_last,
    output logic [PAYLOAD_ADDR_WIDTH-1:0] payload_read_address
);

    logic        capture;
    field_sel_t  field_sel;
    logic [2:0]  byte_index;
    logic [7:0]  field_byte;
    logic        first_fragment;
    logic [15:0] fragment_size;
    logic [15:0] total_length;
    logic [15:0] identification;
    logic [15:0] flags_word;
    logic [31:0] ipv4_source_out;
    logic [31:0] ipv4_destination_out;
    logic [15:0] header_checksum;
    logic        has_credit;
    logic        byte_sent;

    frame_sequencer i_frame_sequencer (
        .clock                (clock),
        .reset_n              (reset_n),
        .start                (start),
        .has_credit           (has_credit),
        .first_fragment       (first_fragment),
        .fragment_size        (fragment_size),
        .field_byte           (field_byte),
        .payload_read_data    (payload_read_data),
        .ready                (ready),
        .capture              (capture),
        .field_sel            (field_sel),
        .byte_index           (byte_index),
        .byte_sent            (byte_sent),
        .frame_data           (frame_data),
        .frame_valid          (frame_valid),
        .frame_last           (frame_last),
        .payload_read_address (payload_read_address)
    );

    header_store i_header_store (
        .clock                (clock),
        .reset_n              (reset_n),
        .capture              (capture),
        .mac_destination      (mac_destination),
        .mac_source           (mac_source),
        .ipv4_source          (ipv4_source),
        .ipv4_destination     (ipv4_destination),
        .ipv4_identification  (ipv4_identification),
        .ipv4_flags           (ipv4_flags),
        .udp_source           (udp_source),
        .udp_destination      (udp_destination),
        .udp_checksum         (udp_checksum),
        .udp_payload_size     (udp_payload_size),
        .udp_fragment_size    (udp_fragment_size),
        .field_sel            (field_sel),
        .byte_index           (byte_index),
        .header_checksum      (header_checksum),
        .field_byte           (field_byte),
        .first_fragment       (first_fragment),
        .fragment_size        (fragment_size),
        .total_length         (total_length),
        .identification       (identification),
        .flags_word           (flags_word),
        .ipv4_source_out      (ipv4_source_out),
        .ipv4_destination_out (ipv4_destination_out)
    );

    ipv4_checksum i_ipv4_checksum (
        .clock                (clock),
        .reset_n              (reset_n),
        .capture              (capture),
        .total_length         (total_length),
        .identification       (identification),
        .flags_word           (flags_word),
        .ipv4_source_out      (ipv4_source_out),
        .ipv4_destination_out (ipv4_destination_out),
        .header_checksum      (header_checksum)
    );

    tx_credit_counter i_tx_credit_counter (
        .clock         (clock),
        .reset_n       (reset_n),
        .byte_sent     (byte_sent),
        .credit_return (credit_return),
        .has_credit    (has_credit)
    );

endmodule

// ==== verilog/frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer import net_proto_pkg::*, frame_gen_pkg::*; (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic                          start,
    input  logic                          has_credit,
    input  logic                          first_fragment,
    input  logic [15:0]                   fragment_size,
    input  logic [7:0]                    field_byte,
    input  logic [7:0]                    payload_read_data,
    output logic                          ready,
    output logic                          capture,
    output field_sel_t                    field_sel,
    output logic [2:0]                    byte_index,
    output logic                          byte_sent,
    output logic [7:0]                    frame_data,
    output logic                          frame_valid,
    output logic                          frame_last,
    output logic [PAYLOAD_ADDR_WIDTH-1:0] payload_read_address
);

    logic       active;
    // Bytes after the MAC header, saturates at the minimum
    logic [5:0] l2_count;
    field_sel_t next_field;
    field_sel_t after_header;
    logic [2:0] next_index;
    logic       final_byte;
    logic [7:0] send_byte;

    function automatic logic [2:0] field_length(input field_sel_t field);
        case (field)
            FIELD_MAC_DESTINATION, FIELD_MAC_SOURCE:                 field_length = 3'd6;
            FIELD_IPV4_SOURCE, FIELD_IPV4_DESTINATION:               field_length = 3'd4;
            FIELD_VERSION_IHL, FIELD_DSCP, FIELD_TTL, FIELD_PROTOCOL: field_length = 3'd1;
            default:                                                 field_length = 3'd2;
        endcase
    endfunction

    assign capture      = start && ready;
    assign byte_sent    = active && has_credit;
    assign after_header = (fragment_size == '0) ? FIELD_PAD : FIELD_PAYLOAD;

    ////////////////////////////////////////////////////////////
    // Position after the current byte
    ////////////////////////////////////////////////////////////

    always_comb begin
        next_field = field_sel;
        next_index = byte_index + 3'd1;
        final_byte = 1'b0;
        case (field_sel)
            FIELD_PAYLOAD: begin
                next_index = '0;
                if (payload_read_address + 1'b1 == fragment_size) begin
                    if (l2_count + 1 < MIN_L2_PAYLOAD_BYTES) begin
                        next_field = FIELD_PAD;
                    end
                    else begin
                        final_byte = 1'b1;
                    end
                end
            end
            FIELD_PAD: begin
                next_index = '0;
                final_byte = (l2_count + 1 >= MIN_L2_PAYLOAD_BYTES);
            end
            default: begin
                if (byte_index == field_length(field_sel) - 3'd1) begin
                    next_index = '0;
                    case (field_sel)
                        FIELD_IPV4_DESTINATION: begin
                            // No UDP header on later fragments
                            next_field = first_fragment ? FIELD_UDP_SOURCE : after_header;
                        end
                        FIELD_UDP_CHECKSUM: next_field = after_header;
                        default:            next_field = field_sel_t'(field_sel + 1);
                    endcase
                end
            end
        endcase
    end

    always_comb begin
        case (field_sel)
            FIELD_PAYLOAD: send_byte = payload_read_data;
            FIELD_PAD:     send_byte = 8'h00;
            default:       send_byte = field_byte;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ready                <= 1'b0;
            active               <= 1'b0;
            field_sel            <= FIELD_MAC_DESTINATION;
            byte_index           <= '0;
            l2_count             <= '0;
            payload_read_address <= '0;
            frame_valid          <= 1'b0;
            frame_last           <= 1'b0;
        end
        else begin
            ready       <= !active && !capture;
            frame_valid <= byte_sent;
            frame_last  <= byte_sent && final_byte;
            if (capture) begin
                active               <= 1'b1;
                field_sel            <= FIELD_MAC_DESTINATION;
                byte_index           <= '0;
                l2_count             <= '0;
                payload_read_address <= '0;
            end
            else if (byte_sent) begin
                field_sel  <= next_field;
                byte_index <= next_index;
                if (field_sel > FIELD_ETHERTYPE && l2_count < MIN_L2_PAYLOAD_BYTES) begin
                    l2_count <= l2_count + 6'd1;
                end
                if (field_sel == FIELD_PAYLOAD) begin
                    payload_read_address <= payload_read_address + 1'b1;
                end
                if (final_byte) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // Outgoing byte
    always_ff @(posedge clock) begin
        if (byte_sent) begin
            frame_data <= send_byte;
        end
    end

endmodule

// ==== verilog/header_store.sv ====
`timescale 1ns/1ps

module header_store import net_proto_pkg::*, frame_gen_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        capture,
    input  logic [47:0] mac_destination,
    input  logic [47:0] mac_source,
    input  logic [31:0] ipv4_source,
    input  logic [31:0] ipv4_destination,
    input  logic [15:0] ipv4_identification,
    input  ipv4_flags_t ipv4_flags,
    input  logic [15:0] udp_source,
    input  logic [15:0] udp_destination,
    input  logic [15:0] udp_checksum,
    input  logic [15:0] udp_payload_size,
    input  logic [15:0] udp_fragment_size,
    input  field_sel_t  field_sel,
    input  logic [2:0]  byte_index,
    input  logic [15:0] header_checksum,
    output logic [7:0]  field_byte,
    output logic        first_fragment,
    output logic [15:0] fragment_size,
    output logic [15:0] total_length,
    output logic [15:0] identification,
    output logic [15:0] flags_word,
    output logic [31:0] ipv4_source_out,
    output logic [31:0] ipv4_destination_out
);

    logic [47:0] saved_mac_destination;
    logic [47:0] saved_mac_source;
    logic [15:0] saved_udp_source;
    logic [15:0] saved_udp_destination;
    logic [15:0] saved_udp_checksum;
    logic [15:0] saved_payload_size;
    ipv4_flags_t saved_flags;
    logic [15:0] udp_length;

    // Big-endian byte of a 16-bit field
    function automatic logic [7:0] word_byte(input logic [15:0] word, input logic [2:0] index);
        word_byte = index[0] ? word[7:0] : word[15:8];
    endfunction

    ////////////////////////////////////////////////////////////
    // Capture
    ////////////////////////////////////////////////////////////

    // Fields that steer the sequencer
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            saved_flags        <= '0;
            fragment_size      <= '0;
            saved_payload_size <= '0;
        end
        else if (capture) begin
            saved_flags        <= ipv4_flags;
            fragment_size      <= udp_fragment_size;
            saved_payload_size <= udp_payload_size;
        end
    end

    always_ff @(posedge clock) begin
        if (capture) begin
            saved_mac_destination <= mac_destination;
            saved_mac_source      <= mac_source;
            ipv4_source_out       <= ipv4_source;
            ipv4_destination_out  <= ipv4_destination;
            identification        <= ipv4_identification;
            saved_udp_source      <= udp_source;
            saved_udp_destination <= udp_destination;
            saved_udp_checksum    <= udp_checksum;
        end
    end

    assign flags_word     = saved_flags.word;
    assign first_fragment = (saved_flags.fields.fragment_offset == '0);
    assign total_length   = 16'(IPV4_HEADER_BYTES) + fragment_size
                          + (first_fragment ? 16'(UDP_HEADER_BYTES) : 16'd0);
    assign udp_length     = saved_payload_size + 16'(UDP_HEADER_BYTES);

    ////////////////////////////////////////////////////////////
    // Byte lookup
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (field_sel)
            FIELD_MAC_DESTINATION:  field_byte = saved_mac_destination[47 - 8 * byte_index -: 8];
            FIELD_MAC_SOURCE:       field_byte = saved_mac_source[47 - 8 * byte_index -: 8];
            FIELD_ETHERTYPE:        field_byte = word_byte(ETHERTYPE_IPV4, byte_index);
            FIELD_VERSION_IHL:      field_byte = IPV4_VERSION_IHL;
            FIELD_DSCP:             field_byte = IPV4_DSCP;
            FIELD_TOTAL_LENGTH:     field_byte = word_byte(total_length, byte_index);
            FIELD_IDENTIFICATION:   field_byte = word_byte(identification, byte_index);
            FIELD_FLAGS:            field_byte = word_byte(saved_flags.word, byte_index);
            FIELD_TTL:              field_byte = IPV4_TTL;
            FIELD_PROTOCOL:         field_byte = IPV4_PROTOCOL_UDP;
            FIELD_HEADER_CHECKSUM:  field_byte = word_byte(header_checksum, byte_index);
            FIELD_IPV4_SOURCE:      field_byte = ipv4_source_out[31 - 8 * byte_index -: 8];
            FIELD_IPV4_DESTINATION: field_byte = ipv4_destination_out[31 - 8 * byte_index -: 8];
            FIELD_UDP_SOURCE:       field_byte = word_byte(saved_udp_source, byte_index);
            FIELD_UDP_DESTINATION:  field_byte = word_byte(saved_udp_destination, byte_index);
            FIELD_UDP_LENGTH:       field_byte = word_byte(udp_length, byte_index);
            FIELD_UDP_CHECKSUM:     field_byte = word_byte(saved_udp_checksum, byte_index);
            default:                field_byte = 8'h00;
        endcase
    end

endmodule

// ==== verilog/ipv4_checksum.sv ====
`timescale 1ns/1ps

module ipv4_checksum import net_proto_pkg::*, frame_gen_pkg::*; (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        capture,
    input  logic [15:0] total_length,
    input  logic [15:0] identification,
    input  logic [15:0] flags_word,
    input  logic [31:0] ipv4_source_out,
    input  logic [31:0] ipv4_destination_out,
    output logic [15:0] header_checksum
);

    logic        busy;
    logic [3:0]  step;
    logic [15:0] word;
    // Nine 16-bit words fit in 20 bits
    logic [19:0] sum;

    // Header words, checksum field itself counted as zero
    always_comb begin
        case (step)
            4'd0:    word = {IPV4_VERSION_IHL, IPV4_DSCP};
            4'd1:    word = total_length;
            4'd2:    word = identification;
            4'd3:    word = flags_word;
            4'd4:    word = {IPV4_TTL, IPV4_PROTOCOL_UDP};
            4'd5:    word = ipv4_source_out[31:16];
            4'd6:    word = ipv4_source_out[15:0];
            4'd7:    word = ipv4_destination_out[31:16];
            4'd8:    word = ipv4_destination_out[15:0];
            default: word = '0;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy <= 1'b0;
            step <= '0;
        end
        else if (capture) begin
            busy <= 1'b1;
            step <= '0;
        end
        else if (busy) begin
            step <= step + 4'd1;
            if (step == 4'd10) begin
                busy <= 1'b0;
            end
        end
    end

    // Accumulate, fold the carries, then complement
    always_ff @(posedge clock) begin
        if (capture) begin
            sum <= '0;
        end
        else if (busy) begin
            if (step < 4'd9) begin
                sum <= sum + word;
            end
            else if (step == 4'd9) begin
                sum <= sum[15:0] + sum[19:16];
            end
            else begin
                header_checksum <= ~(sum[15:0] + sum[16]);
            end
        end
    end

endmodule

// ==== verilog/tx_credit_counter.sv ====
`timescale 1ns/1ps

module tx_credit_counter import frame_gen_pkg::*; (
    input  logic clock,
    input  logic reset_n,
    input  logic byte_sent,
    input  logic credit_return,
    output logic has_credit
);

    logic [CREDIT_WIDTH-1:0] credits;

    // Send and return together leave the count as it is
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            credits <= CREDIT_WIDTH'(TX_CREDITS);
        end
        else begin
            case ({byte_sent, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    assign has_credit = (credits != '0);

endmodule

// ==== verilog/frame_gen_pkg.sv ====
package frame_gen_pkg;

    localparam int TX_CREDITS         = 4;
    localparam int CREDIT_WIDTH       = 3;
    localparam int PAYLOAD_ADDR_WIDTH = 16;

    // Frame fields in transmit order
    typedef enum logic [4:0] {
        FIELD_MAC_DESTINATION,
        FIELD_MAC_SOURCE,
        FIELD_ETHERTYPE,
        FIELD_VERSION_IHL,
        FIELD_DSCP,
        FIELD_TOTAL_LENGTH,
        FIELD_IDENTIFICATION,
        FIELD_FLAGS,
        FIELD_TTL,
        FIELD_PROTOCOL,
        FIELD_HEADER_CHECKSUM,
        FIELD_IPV4_SOURCE,
        FIELD_IPV4_DESTINATION,
        FIELD_UDP_SOURCE,
        FIELD_UDP_DESTINATION,
        FIELD_UDP_LENGTH,
        FIELD_UDP_CHECKSUM,
        FIELD_PAYLOAD,
        FIELD_PAD
    } field_sel_t;

endpackage

// ==== verilog/net_proto_pkg.sv ====
package net_proto_pkg;

    // Ethernet and IPv4 fixed header values
    localparam logic [15:0] ETHERTYPE_IPV4    = 16'h0800;
    localparam logic [7:0]  IPV4_VERSION_IHL  = 8'h45;
    localparam logic [7:0]  IPV4_DSCP         = 8'h00;
    localparam logic [7:0]  IPV4_TTL          = 8'h80;
    localparam logic [7:0]  IPV4_PROTOCOL_UDP = 8'h11;

    // Header sizes in bytes
    localparam int IPV4_HEADER_BYTES    = 20;
    localparam int UDP_HEADER_BYTES     = 8;
    localparam int MIN_L2_PAYLOAD_BYTES = 46;

    // Flags and fragment offset, seen as a header word or as fields
    typedef union packed {
        logic [15:0] word;
        struct packed {
            logic        reserved;
            logic        dont_fragment;
            logic        more_fragments;
            logic [12:0] fragment_offset;
        } fields;
    } ipv4_flags_t;

endpackage
